// File: src/exu_defines.svh
`ifndef EXU_DEFINES_SVH
`define EXU_DEFINES_SVH

// integer datapath width
`define XLEN 64

// opcode field width, wide enough for every alu_op_e value
`define ALU_OP_WIDTH 5

// shift-add steps for one product, one multiplier bit per step
`define MUL_ITERS `XLEN

`endif

// File: src/exu_pkg.sv
`include "exu_defines.svh"

package exu_pkg;

    typedef logic [`XLEN-1:0]   xlen_t;   // operand or result
    typedef logic [2*`XLEN-1:0] dxlen_t;  // full product

    typedef enum logic [`ALU_OP_WIDTH-1:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLLW,
        ALU_SRLW,
        ALU_SRAW,
        ALU_SLT,
        ALU_SLTU,
        ALU_BEQ,    // branch compares
        ALU_BNE,
        ALU_BLT,
        ALU_BGE,
        ALU_BLTU,
        ALU_BGEU,
        ALU_DIVU,
        ALU_REMU,
        ALU_MUL,    // low half of product
        ALU_MULH,   // signed x signed, high half
        ALU_MULHU,  // unsigned x unsigned, high half
        ALU_PASS    // src2 through, loads and upper immediates
    } alu_op_e;

    typedef enum logic [1:0] {
        EXT_NONE,
        EXT_SEXT32,
        EXT_ZEXT32,
        EXT_SEXT16
    } res_ext_e;

endpackage

// File: src/mul_if.sv
`timescale 1ns/1ps

interface mul_if;
    import exu_pkg::*;

    logic   req;        // held while a multiply is pending
    logic   a_signed;
    logic   b_signed;
    xlen_t  src_a;
    xlen_t  src_b;
    dxlen_t prod;       // valid in the done cycle, held until next capture
    logic   done;       // one-cycle pulse
    logic   busy;

    // alu side
    modport requester (
        output req, a_signed, b_signed, src_a, src_b,
        input  prod, done, busy
    );

    // multiplier side
    modport unit (
        input  req, a_signed, b_signed, src_a, src_b,
        output prod, done, busy
    );

endinterface

// File: src/shift_add_mul.sv
`timescale 1ns/1ps
`include "exu_defines.svh"

module shift_add_mul (
    input  logic clk,
    input  logic rst_n,
    mul_if.unit  port
);
    import exu_pkg::*;

    localparam int CNT_W = $clog2(`MUL_ITERS);

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DONE
    } mul_state_e;

    mul_state_e       state;
    logic [CNT_W-1:0] step_cnt;
    logic             start;
    xlen_t            a_mag;
    xlen_t            b_mag;
    dxlen_t           mcand;     // multiplicand, shifted left each step
    xlen_t            mplier;    // consumed from bit 0
    dxlen_t           acc;
    logic             neg;       // product sign

    assign start = port.req && (state != RUN);

    // magnitudes of the operands, min value maps to 2^63 unsigned
    assign a_mag = (port.a_signed && port.src_a[`XLEN-1]) ? -port.src_a : port.src_a;
    assign b_mag = (port.b_signed && port.src_b[`XLEN-1]) ? -port.src_b : port.src_b;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= IDLE;
            step_cnt <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin
                        state    <= RUN;
                        step_cnt <= '0;
                    end
                end
                RUN: begin
                    step_cnt <= step_cnt + 1'b1;
                    if (step_cnt == CNT_W'(`MUL_ITERS - 1)) begin
                        state <= DONE;   // last bit consumed
                    end
                end
                DONE: begin
                    if (start) begin
                        state    <= RUN;
                        step_cnt <= '0;
                    end else begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // shift-add datapath
    always_ff @(posedge clk) begin
        if (start) begin
            mcand  <= {{`XLEN{1'b0}}, a_mag};
            mplier <= b_mag;
            acc    <= '0;
            neg    <= (port.a_signed && port.src_a[`XLEN-1]) ^
                      (port.b_signed && port.src_b[`XLEN-1]);
        end else if (state == RUN) begin
            if (mplier[0]) begin
                acc <= acc + mcand;
            end
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    assign port.prod = neg ? -acc : acc;   // sign fixup after accumulation
    assign port.busy = (state == RUN);
    assign port.done = (state == DONE);

    done_pulse: assert property (
        @(posedge clk) disable iff (!rst_n)
        port.done |=> !port.done
    ) else $error("done held longer than one cycle");

    // requester must not move the operands mid-product
    src_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        port.busy |-> ($stable(port.src_a) && $stable(port.src_b) &&
                       $stable(port.a_signed) && $stable(port.b_signed))
    ) else $error("multiplier operands changed while busy");

endmodule

// File: src/alu.sv
`timescale 1ns/1ps
`include "exu_defines.svh"

module alu (
    input  logic              clk,
    input  logic              rst_n,
    input  exu_pkg::alu_op_e  alu_op,
    input  exu_pkg::xlen_t    src1,
    input  exu_pkg::xlen_t    src2,
    input  exu_pkg::res_ext_e res_ext,
    output exu_pkg::xlen_t    result,
    output logic              branch_taken,
    output logic              stall,
    mul_if                    mul
);
    import exu_pkg::*;

    xlen_t       raw_res;    // before extension
    xlen_t       diff;
    logic [5:0]  shamt;
    logic [4:0]  shamt_w;    // W shifts only look at 5 bits
    logic [31:0] word_lo;
    logic        is_mul;
    logic        is_branch;
    logic        eq;
    logic        lt_s;
    logic        lt_u;

    assign diff    = src1 - src2;
    assign shamt   = src2[5:0];
    assign shamt_w = src2[4:0];
    assign word_lo = src1[31:0];

    assign eq   = (src1 == src2);
    assign lt_s = ($signed(src1) < $signed(src2));
    assign lt_u = (src1 < src2);

    assign is_mul    = alu_op inside {ALU_MUL, ALU_MULH, ALU_MULHU};
    assign is_branch = alu_op inside {ALU_BEQ, ALU_BNE, ALU_BLT,
                                      ALU_BGE, ALU_BLTU, ALU_BGEU};

    // raw result
    always_comb begin
        raw_res = '0;
        case (alu_op)
            ALU_ADD:  raw_res = src1 + src2;
            ALU_SUB:  raw_res = diff;
            ALU_AND:  raw_res = src1 & src2;
            ALU_OR:   raw_res = src1 | src2;
            ALU_XOR:  raw_res = src1 ^ src2;

            ALU_SLL:  raw_res = src1 << shamt;
            ALU_SRL:  raw_res = src1 >> shamt;
            ALU_SRA:  raw_res = $signed(src1) >>> shamt;

            // word shifts, upper half zero or sign filled
            ALU_SLLW: raw_res = {32'b0, word_lo << shamt_w};
            ALU_SRLW: raw_res = {32'b0, word_lo >> shamt_w};
            ALU_SRAW: raw_res = $signed({{32{word_lo[31]}}, word_lo}) >>> shamt_w;

            ALU_SLT:  raw_res = {{(`XLEN-1){1'b0}}, lt_s};
            ALU_SLTU: raw_res = {{(`XLEN-1){1'b0}}, lt_u};

            ALU_BEQ,
            ALU_BNE,
            ALU_BLT,
            ALU_BGE,
            ALU_BLTU,
            ALU_BGEU: raw_res = diff;    // compare via subtract

            ALU_DIVU: begin
                if (src2 == '0) begin
                    raw_res = '1;        // div by zero gives all ones
                end else begin
                    raw_res = src1 / src2;
                end
            end
            ALU_REMU: begin
                if (src2 == '0) begin
                    raw_res = src1;      // rem by zero gives dividend
                end else begin
                    raw_res = src1 % src2;
                end
            end

            ALU_MUL:   raw_res = mul.prod[`XLEN-1:0];
            ALU_MULH,
            ALU_MULHU: raw_res = mul.prod[2*`XLEN-1:`XLEN];

            ALU_PASS:  raw_res = src2;
            default:   raw_res = '0;
        endcase
    end

    // branch condition
    always_comb begin
        case (alu_op)
            ALU_BEQ:  branch_taken = eq;
            ALU_BNE:  branch_taken = !eq;
            ALU_BLT:  branch_taken = lt_s;
            ALU_BGE:  branch_taken = !lt_s;
            ALU_BLTU: branch_taken = lt_u;
            ALU_BGEU: branch_taken = !lt_u;
            default:  branch_taken = 1'b0;
        endcase
    end

    // result extension, same modes for alu and load data
    always_comb begin
        case (res_ext)
            EXT_SEXT32: result = {{32{raw_res[31]}}, raw_res[31:0]};
            EXT_ZEXT32: result = {32'b0, raw_res[31:0]};
            EXT_SEXT16: result = {{48{raw_res[15]}}, raw_res[15:0]};
            default:    result = raw_res;
        endcase
    end

    // multiplier request
    // req drops in the done cycle so the finished operands are not captured again;
    // a multiply presented in the following cycle starts a fresh product
    assign mul.req      = is_mul && !mul.done;
    assign mul.a_signed = (alu_op == ALU_MULH);   // low half is sign agnostic
    assign mul.b_signed = (alu_op == ALU_MULH);
    assign mul.src_a    = src1;
    assign mul.src_b    = src2;

    assign stall = is_mul && !mul.done;

    shift_add_mul u_mul (
        .clk   (clk),
        .rst_n (rst_n),
        .port  (mul.unit)
    );

    // a multiply stall always ends within the fixed latency
    stall_bounded: assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(stall) |-> ##[1:`MUL_ITERS+1] !stall
    ) else $error("stall held past multiplier latency");

    // flag only ever comes from the compare opcodes
    branch_only: assert property (
        @(posedge clk) disable iff (!rst_n)
        !is_branch |-> !branch_taken
    ) else $error("branch_taken set for non-branch opcode");

endmodule

// File: src/exu_top.sv
`timescale 1ns/1ps

module exu_top (
    input  logic              clk,
    input  logic              rst_n,
    input  exu_pkg::alu_op_e  alu_op,
    input  exu_pkg::xlen_t    src1,
    input  exu_pkg::xlen_t    src2,
    input  exu_pkg::res_ext_e res_ext,   // result extension mode
    output exu_pkg::xlen_t    result,
    output logic              branch_taken,
    output logic              stall      // high while a multiply runs
);

    // alu to multiplier link, multiplier sits inside the alu
    mul_if mul_bus ();

    alu u_alu (
        .clk          (clk),
        .rst_n        (rst_n),
        .alu_op       (alu_op),
        .src1         (src1),
        .src2         (src2),
        .res_ext      (res_ext),
        .result       (result),
        .branch_taken (branch_taken),
        .stall        (stall),
        .mul          (mul_bus)
    );

endmodule

// File: verif/exu_model.svh
`ifndef EXU_MODEL_SVH
`define EXU_MODEL_SVH

// reference behavior of the execute stage from the ISA rules

function automatic xlen_t extend_value(input xlen_t v, input res_ext_e ext);
    xlen_t r;
    r = v;
    if (ext == EXT_SEXT32) begin
        r = {{32{v[31]}}, v[31:0]};
    end else if (ext == EXT_ZEXT32) begin
        r = {32'b0, v[31:0]};
    end else if (ext == EXT_SEXT16) begin
        r = {{48{v[15]}}, v[15:0]};
    end
    return r;
endfunction

function automatic void model_execute(input alu_op_e op, input xlen_t a, input xlen_t b,
                                      input res_ext_e ext, output xlen_t res,
                                      output logic taken);
    xlen_t       raw;
    xlen_t       bias;
    xlen_t       ones;
    xlen_t       word_sx;
    logic        less_s;
    logic        less_u;
    logic [31:0] w;
    dxlen_t      full;
    int          sh;
    int          sh_w;
    bias    = xlen_t'(1) << (`XLEN - 1);
    ones    = '1;
    less_u  = (a < b);
    less_s  = ((a ^ bias) < (b ^ bias));   // offset binary turns signed into unsigned
    sh      = b[5:0];
    sh_w    = b[4:0];
    w       = a[31:0];
    word_sx = {{32{w[31]}}, w};
    raw     = '0;
    case (op)
        ALU_ADD:   raw = a + b;
        ALU_SUB:   raw = a - b;
        ALU_AND:   raw = a & b;
        ALU_OR:    raw = a | b;
        ALU_XOR:   raw = a ^ b;
        ALU_SLL:   raw = a << sh;
        ALU_SRL:   raw = a >> sh;
        ALU_SRA:   raw = (a >> sh) | (a[63] ? ~(ones >> sh) : '0);
        ALU_SLLW:  raw = {32'b0, w << sh_w};
        ALU_SRLW:  raw = {32'b0, w >> sh_w};
        ALU_SRAW:  raw = (word_sx >> sh_w) | (w[31] ? ~(ones >> sh_w) : '0);
        ALU_SLT:   raw = xlen_t'(less_s);
        ALU_SLTU:  raw = xlen_t'(less_u);
        ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE, ALU_BLTU, ALU_BGEU: raw = a - b;
        ALU_DIVU:  raw = (b == '0) ? ones : a / b;
        ALU_REMU:  raw = (b == '0) ? a : a % b;
        ALU_MUL: begin
            full = dxlen_t'(a) * dxlen_t'(b);
            raw  = full[`XLEN-1:0];
        end
        ALU_MULH: begin
            // with both sign extended to 128 bits the product mod 2^128 is the signed one
            full = {{`XLEN{a[63]}}, a} * {{`XLEN{b[63]}}, b};
            raw  = full[2*`XLEN-1:`XLEN];
        end
        ALU_MULHU: begin
            full = dxlen_t'(a) * dxlen_t'(b);
            raw  = full[2*`XLEN-1:`XLEN];
        end
        ALU_PASS:  raw = b;
        default:   raw = '0;
    endcase
    case (op)
        ALU_BEQ:   taken = (a == b);
        ALU_BNE:   taken = (a != b);
        ALU_BLT:   taken = less_s;
        ALU_BGE:   taken = !less_s;
        ALU_BLTU:  taken = less_u;
        ALU_BGEU:  taken = !less_u;
        default:   taken = 1'b0;
    endcase
    res = extend_value(raw, ext);
endfunction

`endif

// File: verif/exu_tb.sv
`timescale 1ns/1ps
`include "exu_defines.svh"

module exu_tb;
    import exu_pkg::*;
    `include "exu_model.svh"

    localparam logic [31:0] SEED          = 32'hfb5f7a97;
    localparam int          STALL_TIMEOUT = `MUL_ITERS + 10;
    localparam xlen_t       SIGN_BIT      = xlen_t'(1) << (`XLEN - 1);

    logic        clk;
    logic        rst_n;
    alu_op_e     alu_op;
    xlen_t       src1;
    xlen_t       src2;
    res_ext_e    res_ext;
    xlen_t       result;
    logic        branch_taken;
    logic        stall;

    logic [31:0] lfsr_state;
    int          test_checks;
    int          test_errors;
    int          total_checks;
    int          total_errors;

    exu_top exu_top_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .alu_op       (alu_op),
        .src1         (src1),
        .src2         (src2),
        .res_ext      (res_ext),
        .result       (result),
        .branch_taken (branch_taken),
        .stall        (stall)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;   // 8 ns period
    end

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [63:0] take_bits(input int n);
        logic [63:0] v;
        int          i;
        v = '0;
        for (i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[62:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // roughly one operand in four is a corner value
    function automatic xlen_t rand_operand();
        logic [1:0] kind;
        logic [1:0] corner;
        xlen_t      v;
        kind = 2'(take_bits(2));
        if (kind != 2'd0) begin
            v = take_bits(`XLEN);
        end else begin
            corner = 2'(take_bits(2));
            case (corner)
                2'd0:    v = '0;
                2'd1:    v = '1;
                2'd2:    v = SIGN_BIT;
                default: v = take_bits(4);   // small values
            endcase
        end
        return v;
    endfunction

    task automatic check_value(input alu_op_e op, input string what,
                               input xlen_t exp, input xlen_t obs);
        test_checks++;
        assert (obs === exp) else begin
            $display("Mismatch at time %0t: %s %s expected %h observed %h",
                     $time, op.name(), what, exp, obs);
            test_errors++;
        end
    endtask

    task automatic check_flag(input alu_op_e op, input string what,
                              input logic exp, input logic obs);
        test_checks++;
        assert (obs === exp) else begin
            $display("Mismatch at time %0t: %s %s expected %b observed %b",
                     $time, op.name(), what, exp, obs);
            test_errors++;
        end
    endtask

    task automatic drive_op(input alu_op_e op, input xlen_t a, input xlen_t b,
                            input res_ext_e ext);
        @(posedge clk);
        #1;
        alu_op  = op;
        src1    = a;
        src2    = b;
        res_ext = ext;
    endtask

    task automatic run_comb(input alu_op_e op, input xlen_t a, input xlen_t b,
                            input res_ext_e ext);
        xlen_t exp_res;
        logic  exp_taken;
        drive_op(op, a, b, ext);
        model_execute(op, a, b, ext, exp_res, exp_taken);
        #6;   // sample just before the next edge
        check_flag(op, "stall", 1'b0, stall);
        check_value(op, "result", exp_res, result);
        check_flag(op, "branch_taken", exp_taken, branch_taken);
    endtask

    task automatic run_mul(input alu_op_e op, input xlen_t a, input xlen_t b);
        xlen_t exp_res;
        logic  exp_taken;
        int    cycles;
        drive_op(op, a, b, EXT_NONE);
        model_execute(op, a, b, EXT_NONE, exp_res, exp_taken);
        #6;
        check_flag(op, "stall", 1'b1, stall);
        cycles = 0;
        while (stall && cycles < STALL_TIMEOUT) begin
            @(posedge clk);
            #7;
            cycles++;
        end
        if (stall) begin
            $display("Timeout at time %0t: stall still high %0d cycles after %s was issued",
                     $time, cycles, op.name());
            test_checks++;
            test_errors++;
        end else begin
            check_value(op, "latency", `MUL_ITERS + 1, cycles);   // fixed gap to done
            check_value(op, "result", exp_res, result);
            check_flag(op, "branch_taken", exp_taken, branch_taken);
        end
    endtask

    task automatic start_test();
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic finish_test(input int num, input string name);
        $display("test %0d %s: %0d checks, %0d errors", num, name, test_checks, test_errors);
        total_checks += test_checks;
        total_errors += test_errors;
    endtask

    initial begin
        int       n;
        int       k;
        alu_op_e  op;
        xlen_t    a;
        xlen_t    b;
        res_ext_e ext;

        alu_op       = ALU_ADD;
        src1         = '0;
        src2         = '0;
        res_ext      = EXT_NONE;
        rst_n        = 1'b0;
        lfsr_state   = SEED;
        total_checks = 0;
        total_errors = 0;
        start_test();

        repeat (16) @(posedge clk);
        #1 rst_n = 1'b1;

        start_test();
        for (n = 0; n < 40; n++) begin
            k  = int'(take_bits(3) % 7);
            op = (k < 5) ? alu_op_e'(k) : alu_op_e'(ALU_SLT + k - 5);
            run_comb(op, rand_operand(), rand_operand(), EXT_NONE);
        end
        finish_test(1, "arith, logic and set-less-than");

        start_test();
        for (n = 0; n < 36; n++) begin
            op  = alu_op_e'(ALU_SLL + (n % 6));
            ext = (op >= ALU_SLLW) ? EXT_SEXT32 : EXT_NONE;   // W forms sign extend
            a   = rand_operand();
            b   = take_bits(1) ? take_bits(`XLEN) : take_bits(7);
            run_comb(op, a, b, ext);
        end
        finish_test(2, "shifts");

        start_test();
        for (n = 0; n < 36; n++) begin
            op = alu_op_e'(ALU_BEQ + (n % 6));
            a  = rand_operand();
            case ((n / 6) % 3)
                0:       b = a;
                1:       b = a ^ SIGN_BIT;   // differ only in sign
                default: b = rand_operand();
            endcase
            run_comb(op, a, b, EXT_NONE);
        end
        finish_test(3, "branch compares");

        start_test();
        for (n = 0; n < 30; n++) begin
            op = n[0] ? ALU_REMU : ALU_DIVU;
            a  = rand_operand();
            case (n % 5)
                0:       b = '0;
                1:       b = take_bits(16);
                default: b = rand_operand();
            endcase
            run_comb(op, a, b, EXT_NONE);
        end
        finish_test(4, "unsigned divide and remainder");

        start_test();
        run_mul(ALU_MULH, SIGN_BIT, SIGN_BIT);
        run_mul(ALU_MULHU, '1, '1);
        for (n = 0; n < 15; n++) begin
            op = alu_op_e'(ALU_MUL + (n % 3));
            run_mul(op, rand_operand(), rand_operand());   // issued back to back
        end
        finish_test(5, "multiplies");

        start_test();
        for (n = 0; n < 32; n++) begin
            ext = res_ext_e'(n % 4);
            op  = ((n / 4) % 2) ? ALU_ADD : ALU_PASS;
            run_comb(op, rand_operand(), rand_operand(), ext);
        end
        finish_test(6, "result extension");

        $display("all tests: %0d checks, %0d errors", total_checks, total_errors);
        if (total_errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: files.f
+incdir+src
+incdir+verif
src/exu_pkg.sv
src/mul_if.sv
src/shift_add_mul.sv
src/alu.sv
src/exu_top.sv
verif/exu_tb.sv
